// ==== tb.f ====
+incdir+hdl
hdl/stream_mux_pkg.sv
hdl/mux_cfg_if.sv
hdl/mux_config_regs.sv
hdl/idle_link_mux.sv
hdl/stream_mux_top.sv
testbench/tb_clock_gen.sv
testbench/stream_mux_properties.sv
testbench/stream_mux_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the stream mux testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module stream_mux_tb \
    -f tb.f -o stream_mux_sim || exit 1

./obj_dir/stream_mux_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

# The log decides the result
grep -q "tests failed" sim.log && exit 1
grep -q "all tests passed" sim.log || exit 1
exit 0

// ==== testbench/stream_mux_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "stream_mux_macros.svh"

module stream_mux_tb
    import stream_mux_pkg::*;
();

    localparam int n_inputs       = `STREAM_N_INPUTS;
    localparam int timeout_cycles = 2000;

    localparam reg_addr_t reg_select  = 2'd0;
    localparam reg_addr_t reg_count   = 2'd1;
    localparam reg_addr_t reg_word    = 2'd2;
    localparam reg_addr_t reg_control = 2'd3;

    logic                clk;
    logic                rst_n;
    stream_word_t        in_data [n_inputs];
    logic [n_inputs-1:0] in_valid;
    wire [n_inputs-1:0]  in_ready;
    wire stream_word_t   out_data;
    wire                 out_valid;
    logic                out_ready;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    reg_addr_t           wb_adr;
    stream_word_t        wb_dat_w;
    wire stream_word_t   wb_dat_r;
    wire                 wb_ack;
    logic                link_reset;

    integer              seed;
    int                  error_count;
    int                  checks_done;
    int                  words_taken;
    bit                  stream_en;
    bit                  backpressure;
    logic [n_inputs-1:0] taken;

    // Reference model
    stream_word_t        expected_q [$];
    mux_state_t          model_state;
    int                  idle_left;
    input_sel_t          model_select;
    idle_count_t         model_idle_count;
    stream_word_t        model_idle_word;

    tb_clock_gen clock_gen
    (
        .clk   (clk),
        .rst_n (rst_n)
    );

    stream_mux_top #(
        .reverse_bits (1'b1)
    ) uut
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .link_reset (link_reset)
    );

    bind stream_mux_top stream_mux_properties props
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .wb_ack    (wb_ack)
    );

    //////////////////////////////
    // Model helpers and checks
    //////////////////////////////

    // Bit i goes to bit W-1-i on an LSB first link
    function automatic stream_word_t reverse_word(input stream_word_t word);
        stream_word_t mirrored;
        for (int i = 0; i < `STREAM_DATA_WIDTH; i++)
        begin
            mirrored[i] = word[`STREAM_DATA_WIDTH-1-i];
        end
        return mirrored;
    endfunction

    task automatic check_word(input string name, input stream_word_t actual,
                              input stream_word_t expected);
        checks_done++;
        if (actual !== expected)
        begin
            error_count++;
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_count(input string name, input idle_count_t actual,
                               input idle_count_t expected);
        checks_done++;
        if (actual !== expected)
        begin
            error_count++;
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // Idle words queue up behind any word still held at the output
    task automatic model_restart();
        for (int i = 0; i < int'(model_idle_count); i++)
        begin
            expected_q.push_back(reverse_word(model_idle_word));
        end
        idle_left = idle_left + int'(model_idle_count);
        if (idle_left != 0)
        begin
            model_state = mux_idle_fill;
        end
    endtask

    task automatic check_ready_lines();
        logic [n_inputs-1:0] allowed;
        allowed = '0;
        if (model_state == mux_forward)
        begin
            allowed[model_select] = 1'b1;
        end
        if ((in_ready & ~allowed) != '0)
        begin
            error_count++;
            $display("ERROR in_ready: got %h, allowed %h", in_ready, allowed);
        end
    endtask

    task automatic check_forwarding(input string phase, input int count_before);
        checks_done++;
        if (words_taken == count_before)
        begin
            error_count++;
            $display("No input word was forwarded during %s", phase);
        end
    endtask

    task automatic accept_output();
        stream_word_t expected;
        if (expected_q.size() == 0)
        begin
            error_count++;
            $display("Output word %h arrived while no word was expected", out_data);
        end
        else
        begin
            // Idle words sit at the back until the data ahead has gone
            if (expected_q.size() <= idle_left)
            begin
                idle_left--;
                if (idle_left == 0)
                begin
                    model_state = mux_forward;
                end
            end
            expected = expected_q.pop_front();
            check_word("out_data", out_data, expected);
        end
    endtask

    task automatic track_bus_write();
        if (wb_cyc && wb_stb && wb_we && !wb_ack)
        begin
            case (wb_adr)
                reg_select: model_select = wb_dat_w[1:0];
                reg_count:  model_idle_count = wb_dat_w[15:0];
                reg_word:   model_idle_word = wb_dat_w;
                default:
                begin
                    if (wb_dat_w[0])
                    begin
                        model_restart();
                    end
                end
            endcase
        end
    endtask

    //////////////////////////////
    // Monitor and stimulus
    //////////////////////////////

    // Sampled mid cycle for the handshakes of the next rising edge
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            check_ready_lines();
            taken = in_valid & in_ready;
            if (out_valid && out_ready)
            begin
                accept_output();
            end
            for (int i = 0; i < n_inputs; i++)
            begin
                if (taken[i])
                begin
                    expected_q.push_back(reverse_word(in_data[i]));
                    words_taken++;
                end
            end
            track_bus_write();
            if (link_reset)
            begin
                model_restart();
            end
        end
        else
        begin
            taken = '0;
        end
    end

    // Valid stays up with its data until the word is taken
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            #1;
            for (int i = 0; i < n_inputs; i++)
            begin
                if (!in_valid[i] || taken[i])
                begin
                    in_valid[i] = stream_en && (($random(seed) & 3) != 0);
                    in_data[i]  = $random(seed);
                end
            end
            out_ready = backpressure ? (($random(seed) & 3) != 0) : 1'b1;
        end
    end

    //////////////////////////////
    // Bus and wait tasks
    //////////////////////////////

    task automatic bus_cycle(input logic write, input reg_addr_t addr,
                             input stream_word_t data, output stream_word_t rdata);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = write;
        wb_adr   = addr;
        wb_dat_w = data;
        while (!wb_ack && cycles < timeout_cycles)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!wb_ack)
        begin
            error_count++;
            $display("Wishbone access to register %0d was never acknowledged", addr);
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic reg_write(input reg_addr_t addr, input stream_word_t data);
        stream_word_t unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic reg_read(input reg_addr_t addr, output stream_word_t data);
        bus_cycle(1'b0, addr, '0, data);
    endtask

    task automatic pulse_link_reset();
        @(posedge clk);
        #1;
        link_reset = 1'b1;
        @(posedge clk);
        #1;
        link_reset = 1'b0;
    endtask

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_for_forward(input string cause);
        int cycles;
        cycles = 0;
        while (model_state != mux_forward && cycles < timeout_cycles)
        begin
            @(posedge clk);
            cycles++;
        end
        #1;
        if (model_state != mux_forward)
        begin
            error_count++;
            $display("Idle fill after %s did not finish in time", cause);
        end
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 && cycles < timeout_cycles)
        begin
            @(posedge clk);
            cycles++;
        end
        #1;
        if (expected_q.size() != 0)
        begin
            error_count++;
            $display("%0d expected words never came out", expected_q.size());
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial
    begin
        stream_word_t rdata;
        int           cycles;
        int           taken_before;
        seed         = 32'haa1d;
        error_count  = 0;
        checks_done  = 0;
        words_taken  = 0;
        stream_en    = 1'b1;
        backpressure = 1'b0;
        taken        = '0;
        in_valid     = '0;
        for (int i = 0; i < n_inputs; i++)
        begin
            in_data[i] = '0;
        end
        out_ready  = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        link_reset = 1'b0;

        // Reset values, and the fill that follows reset
        model_select     = '0;
        model_idle_count = `MUX_IDLE_COUNT_RESET;
        model_idle_word  = `MUX_IDLE_WORD_RESET;
        idle_left        = 0;
        model_state      = mux_forward;
        model_restart();

        cycles = 0;
        while (!rst_n && cycles < timeout_cycles)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!rst_n)
        begin
            error_count++;
            $display("Reset was never released");
        end

        // Idle fill after reset, then input 0
        taken_before = words_taken;
        wait_for_forward("reset");
        run_cycles(60);
        check_forwarding("input 0 after reset", taken_before);

        // Read back drops the upper bits
        reg_write(reg_count, 32'hffff_000a);
        reg_read(reg_count, rdata);
        check_word("wb_dat_r", rdata, 32'h0000_000a);
        reg_write(reg_word, 32'h1234_abcd);
        reg_read(reg_word, rdata);
        check_word("wb_dat_r", rdata, 32'h1234_abcd);

        // Pin restart under back-pressure
        backpressure = 1'b1;
        pulse_link_reset();
        reg_read(reg_control, rdata);
        checks_done++;
        if (rdata > stream_word_t'(model_idle_count))
        begin
            error_count++;
            $display("ERROR idle_remaining: got %h, above the programmed %h",
                     rdata, model_idle_count);
        end
        wait_for_forward("link_reset pin");
        reg_read(reg_control, rdata);
        check_count("idle_remaining", rdata[15:0], 16'd0);
        run_cycles(40);

        // Zero idle count goes straight to forwarding
        reg_write(reg_count, 32'h0000_0000);
        pulse_link_reset();
        run_cycles(40);

        // Every select value in turn
        for (int s = 0; s < n_inputs; s++)
        begin
            reg_write(reg_select, 32'hffff_fff0 | s);
            reg_read(reg_select, rdata);
            check_word("wb_dat_r", rdata, stream_word_t'(s));
            taken_before = words_taken;
            run_cycles(50);
            check_forwarding($sformatf("select %0d", s), taken_before);
        end

        // Control write with bit 0 clear does nothing
        reg_write(reg_count, 32'h0000_0007);
        reg_write(reg_control, 32'h0000_0002);
        run_cycles(20);
        reg_write(reg_control, 32'h0000_0001);
        wait_for_forward("control write");
        run_cycles(40);

        // Drain, then make sure nothing extra shows up
        stream_en    = 1'b0;
        backpressure = 1'b0;
        wait_for_drain();
        run_cycles(20);

        error_count = error_count + int'(uut.props.failures);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks_done, error_count, uut.props.failures);
        if (error_count == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/stream_mux_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "stream_mux_macros.svh"

module stream_mux_properties
    import stream_mux_pkg::*;
(
    input wire                        clk,
    input wire                        rst_n,
    input wire stream_word_t          out_data,
    input wire                        out_valid,
    input wire                        out_ready,
    input wire [`STREAM_N_INPUTS-1:0] in_ready,
    input wire                        wb_ack
);

    // Read by the testbench at the end of the run
    int unsigned failures;

    initial
    begin
        failures = 0;
    end

    //////////////////////////////
    // Stream handshakes
    //////////////////////////////

    // Stalled output word stays put
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
    else
    begin
        $error("out_data or out_valid changed while stalled");
        failures++;
    end

    // One input served at a time
    a_one_ready: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(in_ready))
    else
    begin
        $error("more than one in_ready high");
        failures++;
    end

    //////////////////////////////
    // Wishbone
    //////////////////////////////

    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
    else
    begin
        $error("wb_ack high for two cycles in a row");
        failures++;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen
#(
    parameter int half_period  = 20,
    parameter int reset_cycles = 8
)
(
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(half_period) clk = ~clk;
        end
    end

    // Released just after the last reset edge, like the other inputs
    initial
    begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== hdl/stream_mux_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "stream_mux_macros.svh"

module stream_mux_top
    import stream_mux_pkg::*;
#(
    parameter bit reverse_bits = 1'b1
)
(
    input  wire                          clk,
    input  wire                          rst_n,

    // Input streams
    input  wire stream_word_t            in_data [`STREAM_N_INPUTS],
    input  wire [`STREAM_N_INPUTS-1:0]   in_valid,
    output wire [`STREAM_N_INPUTS-1:0]   in_ready,

    // Output stream to the serializer
    output wire stream_word_t            out_data,
    output wire                          out_valid,
    input  wire                          out_ready,

    // Wishbone classic slave
    input  wire                          wb_cyc,
    input  wire                          wb_stb,
    input  wire                          wb_we,
    input  wire reg_addr_t               wb_adr,
    input  wire stream_word_t            wb_dat_w,
    output wire stream_word_t            wb_dat_r,
    output wire                          wb_ack,

    // Fast control
    input  wire                          link_reset
);

    idle_count_t idle_remaining;

    // Configuration from registers to core
    mux_cfg_if cfg_bus ();

    mux_config_regs config_regs
    (
        .clk            (clk),
        .rst_n          (rst_n),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .link_reset     (link_reset),
        .idle_remaining (idle_remaining),
        .cfg            (cfg_bus.cfg_source)
    );

    idle_link_mux #(
        .reverse_bits (reverse_bits)
    ) mux_core
    (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg            (cfg_bus.cfg_sink),
        .in_data        (in_data),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .out_data       (out_data),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .idle_remaining (idle_remaining)
    );

endmodule

`default_nettype wire

// ==== hdl/idle_link_mux.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "stream_mux_macros.svh"

module idle_link_mux
    import stream_mux_pkg::*;
#(
    parameter bit reverse_bits = 1'b0
)
(
    input  wire                          clk,
    input  wire                          rst_n,

    mux_cfg_if.cfg_sink                  cfg,

    // Input streams
    input  wire stream_word_t            in_data [`STREAM_N_INPUTS],
    input  wire [`STREAM_N_INPUTS-1:0]   in_valid,
    output logic [`STREAM_N_INPUTS-1:0]  in_ready,

    // Output stream
    output stream_word_t                 out_data,
    output logic                         out_valid,
    input  wire                          out_ready,

    // Idle words still to send
    output idle_count_t                  idle_remaining
);

    mux_state_t   state;
    idle_count_t  idle_cnt;
    idle_count_t  cnt_next;
    logic         out_is_idle;
    logic         out_take;
    logic         out_free;
    logic         idle_take;
    logic         idle_load;
    logic         fwd_load;
    logic         load_en;
    logic         sel_valid;
    stream_word_t sel_data;
    stream_word_t load_word;
    stream_word_t load_word_ordered;

    //////////////////////////////
    // Output register status
    //////////////////////////////

    assign out_take  = out_valid && out_ready;
    assign out_free  = !out_valid || out_ready;

    // Only idle words count down, a leftover data word does not
    assign idle_take = out_take && out_is_idle;
    assign cnt_next  = idle_take ? idle_cnt - 1'b1 : idle_cnt;

    assign idle_remaining = idle_cnt;

    //////////////////////////////
    // Input selection
    //////////////////////////////

    assign sel_data  = in_data[cfg.output_select];
    assign sel_valid = in_valid[cfg.output_select];

    // Nothing new is taken in the restart cycle itself
    always_comb
    begin
        in_ready = '0;
        if (state == mux_forward && out_free && !cfg.link_restart)
        begin
            in_ready[cfg.output_select] = 1'b1;
        end
    end

    assign fwd_load  = sel_valid && in_ready[cfg.output_select];
    assign idle_load = (state == mux_idle_fill) && out_free && !cfg.link_restart &&
                       (cnt_next != '0);
    assign load_en   = idle_load || fwd_load;
    assign load_word = idle_load ? cfg.idle_word : sel_data;

    // LSB first links want the word mirrored
    generate
        if (reverse_bits)
        begin : g_reverse
            assign load_word_ordered = {<<{load_word}};
        end
        else
        begin : g_straight
            assign load_word_ordered = load_word;
        end
    endgenerate

    //////////////////////////////
    // FSM and idle counter
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n || cfg.link_restart)
        begin
            // A zero count skips idle fill entirely
            state    <= (cfg.idle_count == '0) ? mux_forward : mux_idle_fill;
            idle_cnt <= cfg.idle_count;
        end
        else if (state == mux_idle_fill)
        begin
            idle_cnt <= cnt_next;
            if (cnt_next == '0)
            begin
                state <= mux_forward;
            end
        end
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_valid   <= 1'b0;
            out_is_idle <= 1'b0;
        end
        else if (load_en)
        begin
            out_valid   <= 1'b1;
            out_is_idle <= idle_load;
        end
        else if (out_take)
        begin
            out_valid   <= 1'b0;
            out_is_idle <= 1'b0;
        end
        else if (cfg.link_restart)
        begin
            // Held word goes out ahead of the new idle words
            out_is_idle <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_en)
        begin
            out_data <= load_word_ordered;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mux_config_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "stream_mux_macros.svh"

module mux_config_regs
    import stream_mux_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,

    // Wishbone classic slave
    input  wire               wb_cyc,
    input  wire               wb_stb,
    input  wire               wb_we,
    input  wire reg_addr_t    wb_adr,
    input  wire stream_word_t wb_dat_w,
    output stream_word_t      wb_dat_r,
    output logic              wb_ack,

    // Fast control pin
    input  wire               link_reset,

    // Live status from the core
    input  wire idle_count_t  idle_remaining,

    mux_cfg_if.cfg_source     cfg
);

    localparam reg_addr_t addr_select  = reg_addr_t'(0);
    localparam reg_addr_t addr_count   = reg_addr_t'(1);
    localparam reg_addr_t addr_word    = reg_addr_t'(2);
    localparam reg_addr_t addr_control = reg_addr_t'(3);

    logic         wb_req;
    logic         wb_write;
    logic         ctrl_restart;
    stream_word_t rd_data;

    //////////////////////////////
    // Bus handshake
    //////////////////////////////

    // New request only while no ack is pending
    assign wb_req   = wb_cyc && wb_stb && !wb_ack;
    assign wb_write = wb_req && wb_we;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wb_ack <= 1'b0;
        end
        else
        begin
            wb_ack <= wb_req;
        end
    end

    //////////////////////////////
    // Configuration registers
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cfg.output_select <= '0;
            cfg.idle_count    <= `MUX_IDLE_COUNT_RESET;
            cfg.idle_word     <= `MUX_IDLE_WORD_RESET;
        end
        else if (wb_write)
        begin
            case (wb_adr)
                addr_select: cfg.output_select <= wb_dat_w[$bits(input_sel_t)-1:0];
                addr_count:  cfg.idle_count    <= wb_dat_w[$bits(idle_count_t)-1:0];
                addr_word:   cfg.idle_word     <= wb_dat_w;
                default:     ;
            endcase
        end
    end

    // Control bit 0 restarts the link like the pin does
    assign ctrl_restart = wb_write && (wb_adr == addr_control) && wb_dat_w[0];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cfg.link_restart <= 1'b0;
        end
        else
        begin
            cfg.link_restart <= link_reset || ctrl_restart;
        end
    end

    //////////////////////////////
    // Read back
    //////////////////////////////

    always_comb
    begin
        case (wb_adr)
            addr_select: rd_data = stream_word_t'(cfg.output_select);
            addr_count:  rd_data = stream_word_t'(cfg.idle_count);
            addr_word:   rd_data = cfg.idle_word;
            default:     rd_data = stream_word_t'(idle_remaining);
        endcase
    end

    // Captured with the ack so it is valid for the whole ack cycle
    always_ff @(posedge clk)
    begin
        if (wb_req)
        begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mux_cfg_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface mux_cfg_if
    import stream_mux_pkg::*;
();

    // Which input goes to the output
    input_sel_t   output_select;

    // Idle words to send after each restart
    idle_count_t  idle_count;

    // Pattern sent while idling
    stream_word_t idle_word;

    // Single cycle restart request
    logic         link_restart;

    // Register block side
    modport cfg_source
    (
        output output_select,
        output idle_count,
        output idle_word,
        output link_restart
    );

    // Mux core side
    modport cfg_sink
    (
        input output_select,
        input idle_count,
        input idle_word,
        input link_restart
    );

endinterface

`default_nettype wire

// ==== hdl/stream_mux_pkg.sv ====
`default_nettype none

`include "stream_mux_macros.svh"

package stream_mux_pkg;

    //////////////////////////////
    // Datapath widths
    //////////////////////////////

    // One word on any stream
    typedef logic [`STREAM_DATA_WIDTH-1:0] stream_word_t;

    // Index of the input that feeds the output
    typedef logic [$clog2(`STREAM_N_INPUTS)-1:0] input_sel_t;

    // Number of idle words sent after a restart
    typedef logic [15:0] idle_count_t;

    //////////////////////////////
    // Register block
    //////////////////////////////

    // Word index on the Wishbone bus
    typedef logic [$clog2(`MUX_N_REGS)-1:0] reg_addr_t;

    //////////////////////////////
    // Core FSM
    //////////////////////////////

    // Idle fill first, then forwarding of the selected input
    typedef enum logic
    {
        mux_idle_fill,
        mux_forward
    } mux_state_t;

endpackage

`default_nettype wire

// ==== hdl/stream_mux_macros.svh ====
`ifndef STREAM_MUX_MACROS_SVH
`define STREAM_MUX_MACROS_SVH

// Stream geometry
`define STREAM_DATA_WIDTH 32
`define STREAM_N_INPUTS 4

// Register block size in 32 bit words
`define MUX_N_REGS 4

// Register reset values
`define MUX_IDLE_COUNT_RESET 16'd16
`define MUX_IDLE_WORD_RESET 32'haccccccc

`endif
